/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only -Wall --timing
TOP       = mvu_top_tb
FILELIST  = mvu_top.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "Run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/mvu_cfg_pkg.sv */
// MVU lane configuration: field widths, pipeline latencies and bank geometry
package mvu_cfg_pkg;

    // Host configuration fields, precision and length hold value minus one
    localparam int BPREC    = 6;   // Precision field width
    localparam int BLENGTH  = 10;  // Row count field width
    localparam int BQMSBIDX = 5;   // Quantizer MSB index width

    // Bank geometry
    localparam int BWBANKA = 9;    // Weight bank address width
    localparam int BDBANKA = 10;   // Data bank address width

    // Datapath width
    localparam int BACC = 32;      // Accumulator and result width

    // Pipeline depths, these set the issue to result latency
    localparam int MEMRDLATENCY = 2;  // Bank read latency
    localparam int VVPSTAGES    = 2;  // Product pipeline depth

endpackage

/* common/mvu_ctrl_pkg.sv */
// MVU lane control encodings: job controller states and accumulator operations
package mvu_ctrl_pkg;

    // Job controller states
    typedef enum logic [2:0] {
        job_idle,         // Waiting for start
        job_wait_credit,  // Between rows, no result credit yet
        job_issue,        // Row planes going to the banks
        job_drain,        // All rows issued, waiting for the last sum
        job_finish        // Last result leaving, irq cycle
    } job_state_t;

    // Per-plane operation applied by the shift accumulator
    typedef enum logic [2:0] {
        acc_hold,         // No term this cycle
        acc_first,        // Load term into inner sum
        acc_accum,        // Inner shift and add
        acc_close_plane,  // Fold inner sum into outer sum
        acc_close_row     // Outer sum complete, present row result
    } acc_op_t;

endpackage

/* datapath/bitserial_vvp.sv */
// Bit-serial vector product: AND-popcount of two bit-planes with sign negation
`timescale 1ns/10ps

module bitserial_vvp
    import mvu_cfg_pkg::*;
    import mvu_ctrl_pkg::*;
#(
    parameter int N = 16  // Plane width
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [N-1:0]    iword,
    input  logic [N-1:0]    wword,
    input  logic            neg,
    input  logic            first,
    input  logic            plane_last,
    input  logic            row_last,
    output logic [BACC-1:0] term,
    output acc_op_t         op
);

    localparam int PW = $clog2(N) + 1;  // Popcount width

    logic [PW-1:0] pop_s1;
    logic [3:0]    fl [VVPSTAGES-1];  // {neg, first, plane_last, row_last}
    logic [3:0]    fl_s1;
    logic          in_plane;          // Between first and plane close

    assign fl_s1 = fl[VVPSTAGES-2];

    // Stage 1 plane product and popcount
    always_ff @(posedge clk) begin
        pop_s1 <= PW'($countones(iword & wword));
        if (rst) begin
            for (int i = 0; i < VVPSTAGES - 1; i++) fl[i] <= '0;
        end else begin
            fl[0] <= {neg, first, plane_last, row_last};
            for (int i = 1; i < VVPSTAGES - 1; i++) fl[i] <= fl[i-1];
        end
    end

    // Stage 2 signed term and accumulator op
    always_ff @(posedge clk) begin
        term <= fl_s1[3] ? -BACC'(pop_s1) : BACC'(pop_s1);  // MSB weight is negative
        if (rst) begin
            op       <= acc_hold;
            in_plane <= 1'b0;
        end else begin
            in_plane <= (fl_s1[2] || in_plane) && !fl_s1[1];
            if (fl_s1[0]) op <= acc_close_row;
            else if (fl_s1[1]) op <= acc_close_plane;
            else if (fl_s1[2]) op <= acc_first;
            else if (in_plane) op <= acc_accum;
            else op <= acc_hold;  // Stall gap between rows
        end
    end

endmodule

/* datapath/quant_out.sv */
// Output quantizer: picks a bit window of each row sum onto the result stream
`timescale 1ns/10ps

module quant_out
    import mvu_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                row_valid,
    input  logic [BACC-1:0]     row_sum,
    input  logic [BQMSBIDX-1:0] quant_msbidx,  // Top bit of window
    input  logic [BPREC-1:0]    oprecision,    // Window bits minus one
    output logic                result_valid,
    output logic [BACC-1:0]     result_data
);

    logic [BACC-1:0] win;  // Window right aligned

    always_comb begin
        int src;
        win = '0;
        for (int k = 0; k < BACC; k++) begin
            src = int'(quant_msbidx) + k - int'(oprecision);
            if (k <= int'(oprecision) && src >= 0) begin
                win[k] = row_sum[src];  // Below bit 0 reads zero
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= row_valid;
        end
        if (row_valid) result_data <= win;
    end

endmodule

/* datapath/shift_acc.sv */
// Two-level MSB-first shift accumulator, inner over input bits, outer over weight bits
`timescale 1ns/10ps

module shift_acc
    import mvu_cfg_pkg::*;
    import mvu_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [BACC-1:0] term,
    input  acc_op_t         op,
    output logic            row_valid,
    output logic [BACC-1:0] row_sum
);

    logic [BACC-1:0] inner;      // Current input-bit Horner sum
    logic [BACC-1:0] outer;      // Folded weight planes
    logic [BACC-1:0] plane_val;  // Inner sum including this term

    assign plane_val = (inner << 1) + term;

    always_ff @(posedge clk) begin
        if (rst) begin
            inner     <= '0;
            outer     <= '0;
            row_valid <= 1'b0;
        end else begin
            row_valid <= 1'b0;
            case (op)
                acc_first: inner <= term;
                acc_accum: inner <= plane_val;
                acc_close_plane: begin
                    outer <= (outer << 1) + plane_val;
                    inner <= '0;  // Ready for single-bit planes
                end
                acc_close_row: begin
                    row_sum   <= (outer << 1) + plane_val;
                    row_valid <= 1'b1;
                    outer     <= '0;
                    inner     <= '0;
                end
                default: ;  // Hold
            endcase
        end
    end

endmodule

/* dv/mvu_top_tb.sv */
// Testbench for the MVU lane: table-driven jobs checked against a dot-product model
`timescale 1ns/10ps

module mvu_top_tb
    import mvu_cfg_pkg::*;
();

    localparam int N       = 16;     // Default vector length
    localparam int NCREDIT = 4;      // Default credit pool
    localparam int SEED    = 55603;
    localparam int NJOBS   = 7;
    localparam int MAXROWS = 16;

    // Columns: iprec wprec dsigned wsigned ibase wbase olen qmsb oprec credit_mode mid_start
    // Credit mode 0 returns at once, 1 after 0 to 20 cycles, 2 withholds 30 to 60 cycles
    int jobs [NJOBS][11] = '{
        '{1, 1, 0, 0,   0,   0,  5, 31, 31, 0, 0},  // Unsigned, full word, timed
        '{3, 2, 0, 0,  40,  50,  7,  9,  7, 1, 1},  // Unsigned window, restart ignored
        '{3, 3, 1, 0, 100, 120,  4, 31, 31, 0, 0},  // Signed data, timed
        '{2, 3, 1, 1, 200, 200,  9,  3,  7, 2, 0},  // Both signed, window below bit 0
        '{0, 0, 0, 0, 300, 300, 11,  4,  4, 1, 0},  // Single plane rows
        '{4, 1, 0, 1, 500, 400,  3, 12,  5, 0, 1},  // Signed weights, timed
        '{5, 4, 1, 1, 900, 450,  2, 20, 15, 2, 0}   // Wide operands, slow credits
    };

    logic                clk;
    logic                rst;
    logic                start;
    logic                done;
    logic                irq;
    logic                d_signed;
    logic                w_signed;
    logic [BPREC-1:0]    iprecision;
    logic [BPREC-1:0]    wprecision;
    logic [BPREC-1:0]    oprecision;
    logic [BQMSBIDX-1:0] quant_msbidx;
    logic [BDBANKA-1:0]  ibaseaddr;
    logic [BWBANKA-1:0]  wbaseaddr;
    logic [BLENGTH-1:0]  olength;
    logic                wrw_en;
    logic [BWBANKA-1:0]  wrw_addr;
    logic [N-1:0]        wrw_word;
    logic                wrc_en;
    logic [BDBANKA-1:0]  wrc_addr;
    logic [N-1:0]        wrc_word;
    logic                result_credit = 1'b0;  // Driven by the credit returner
    logic                result_valid;
    logic [BACC-1:0]     result_data;

    int              errors       = 0;
    int              checks       = 0;
    int              cyc          = 0;  // Posedges so far
    int              limit        = 0;  // Timeout in cycles
    logic [BACC-1:0] exp_q [$];         // Expected results in row order
    int              due_q [$];         // Cycles at which credits go back
    int              outstanding  = 0;  // Results not yet credited
    int              credit_mode  = 0;
    bit              job_active   = 1'b0;
    int              irq_cnt      = 0;
    int              last_res_cyc = 0;
    int              cur_job      = 0;
    int              row_idx      = 0;

    mvu_top #(.N(N), .NCREDIT(NCREDIT)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // Cycle count and watchdog
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc > limit) begin
            $display("Timeout: the jobs did not finish within %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input longint expected, input longint actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Operand value from its bit pattern, MSB weighs negative when signed
    function automatic int to_value(input int raw, input int bits, input int sgn);
        if (sgn != 0 && raw[bits-1]) return raw - (1 << bits);
        return raw;
    endfunction

    // Output bits msb down to msb-oprec, zero below bit 0
    function automatic logic [BACC-1:0] select_window(input logic [BACC-1:0] sum,
                                                      input int msb, input int oprec);
        longint mask;
        longint w;
        mask = (longint'(1) << (oprec + 1)) - 1;
        if (msb >= oprec) w = longint'(sum) >> (msb - oprec);
        else w = longint'(sum) << (oprec - msb);
        return BACC'(w & mask);
    endfunction

    // Issue cycles, loading and credit margins over all jobs, doubled
    function automatic int timeout_limit();
        int total;
        int rows;
        total = 100;  // Reset and idle gaps
        for (int j = 0; j < NJOBS; j++) begin
            rows = jobs[j][6] + 1;
            total += rows * (jobs[j][0] + 1) * (jobs[j][1] + 1);
            total += rows * 60 + rows * (jobs[j][1] + 1) + jobs[j][0] + 21;
        end
        return 2 * total;
    endfunction

    task automatic write_word(input bit to_weights, input int addr, input logic [N-1:0] word);
        if (to_weights) begin
            wrw_en   = 1'b1;
            wrw_addr = BWBANKA'(addr);
            wrw_word = word;
        end else begin
            wrc_en   = 1'b1;
            wrc_addr = BDBANKA'(addr);
            wrc_word = word;
        end
        @(negedge clk);
        wrw_en = 1'b0;
        wrc_en = 1'b0;
    endtask

    // Result checker and credit returner
    always @(negedge clk) begin
        int              delay;
        logic [BACC-1:0] expected;
        if (!rst) begin
            if (irq && !result_valid) begin
                errors++;
                $display("irq pulsed in a cycle without a result");
            end
            if (job_active && done && !result_valid) begin
                errors++;
                $display("done rose before the last result of job %0d", cur_job);
            end
            if (!job_active && irq_cnt > 0 && !done) begin
                errors++;
                $display("done fell after job %0d before the next start", cur_job);
            end
            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("A result arrived while none was expected");
                end else begin
                    expected = exp_q.pop_front();
                    check_value($sformatf("job %0d row %0d result", cur_job, row_idx),
                                expected, result_data);
                    check_value($sformatf("job %0d row %0d done", cur_job, row_idx),
                                exp_q.size() == 0, done);
                    check_value($sformatf("job %0d row %0d irq", cur_job, row_idx),
                                exp_q.size() == 0, irq);
                    row_idx++;
                    if (exp_q.size() == 0) job_active = 1'b0;
                end
                last_res_cyc = cyc;
                if (irq) irq_cnt++;
                case (credit_mode)
                    0: delay = 0;
                    1: delay = $urandom_range(20, 0);
                    default: delay = 30 + $urandom_range(30, 0);  // Long stall
                endcase
                due_q.push_back(cyc + delay);
                outstanding++;
                if (outstanding > NCREDIT) begin
                    errors++;
                    $display("More than %0d results are waiting for credit", NCREDIT);
                end
            end
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                void'(due_q.pop_front());
                result_credit = 1'b1;  // One credit per cycle
                outstanding--;
            end else begin
                result_credit = 1'b0;
            end
        end
    end

    task automatic run_job(input int j);
        int           ip;
        int           wp;
        int           rows;
        int           planes;
        int           start_cyc;
        int           xraw [N];
        int           wraw [MAXROWS][N];
        longint       acc;
        logic [N-1:0] word;
        ip     = jobs[j][0];
        wp     = jobs[j][1];
        rows   = jobs[j][6] + 1;
        planes = (ip + 1) * (wp + 1);
        while (outstanding != 0) @(negedge clk);  // Full credit pool for the next job
        for (int e = 0; e < N; e++) xraw[e] = $urandom & ((1 << (ip + 1)) - 1);
        for (int r = 0; r < rows; r++) begin
            for (int e = 0; e < N; e++) wraw[r][e] = $urandom & ((1 << (wp + 1)) - 1);
        end
        for (int b = 0; b <= ip; b++) begin  // Input plane b at ibase + b
            for (int e = 0; e < N; e++) word[e] = xraw[e][b];
            write_word(1'b0, jobs[j][4] + b, word);
        end
        for (int r = 0; r < rows; r++) begin  // Row r plane b at wbase + r*(wp+1) + b
            for (int b = 0; b <= wp; b++) begin
                for (int e = 0; e < N; e++) word[e] = wraw[r][e][b];
                write_word(1'b1, jobs[j][5] + r * (wp + 1) + b, word);
            end
        end
        for (int r = 0; r < rows; r++) begin
            acc = 0;
            for (int e = 0; e < N; e++) begin
                acc += longint'(to_value(xraw[e], ip + 1, jobs[j][2]))
                     * to_value(wraw[r][e], wp + 1, jobs[j][3]);
            end
            exp_q.push_back(select_window(BACC'(acc), jobs[j][7], jobs[j][8]));
        end
        iprecision   = BPREC'(ip);
        wprecision   = BPREC'(wp);
        d_signed     = jobs[j][2] != 0;
        w_signed     = jobs[j][3] != 0;
        ibaseaddr    = BDBANKA'(jobs[j][4]);
        wbaseaddr    = BWBANKA'(jobs[j][5]);
        olength      = BLENGTH'(jobs[j][6]);
        quant_msbidx = BQMSBIDX'(jobs[j][7]);
        oprecision   = BPREC'(jobs[j][8]);
        cur_job      = j;
        row_idx      = 0;
        irq_cnt      = 0;
        credit_mode  = jobs[j][9];
        check_value($sformatf("job %0d done before start", j), j > 0, done);
        start     = 1'b1;
        start_cyc = cyc + 1;  // Edge that samples start
        @(negedge clk);
        start      = 1'b0;
        job_active = 1'b1;
        if (jobs[j][10] != 0) begin  // Second start while busy
            repeat (5) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        while (!done) @(negedge clk);
        @(negedge clk);  // Checker has taken the last result
        check_value($sformatf("job %0d results left", j), 0, exp_q.size());
        check_value($sformatf("job %0d irq count", j), 1, irq_cnt);
        if (credit_mode == 0) begin  // Wait cycle, issue cycles, then 6 cycles of latency
            check_value($sformatf("job %0d last result cycle", j),
                        start_cyc + rows * planes + 6, last_res_cyc);
        end
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        d_signed     = 1'b0;
        w_signed     = 1'b0;
        iprecision   = '0;
        wprecision   = '0;
        oprecision   = '0;
        quant_msbidx = '0;
        ibaseaddr    = '0;
        wbaseaddr    = '0;
        olength      = '0;
        wrw_en       = 1'b0;
        wrw_addr     = '0;
        wrw_word     = '0;
        wrc_en       = 1'b0;
        wrc_addr     = '0;
        wrc_word     = '0;
        void'($urandom(SEED));
        limit = timeout_limit();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (5) begin  // Quiet outputs before the first start
            @(negedge clk);
            check_value("reset done", 0, done);
            check_value("reset irq", 0, irq);
            check_value("reset result_valid", 0, result_valid);
        end
        for (int j = 0; j < NJOBS; j++) run_job(j);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/bank_ram.sv */
// Operand bank: one write port, one read port with two-cycle read latency
`timescale 1ns/10ps

module bank_ram #(
    parameter int WIDTH = 16,  // Word width, one bit-plane
    parameter int AW    = 9    // Address width
) (
    input  logic             clk,
    input  logic             wr_en,
    input  logic [AW-1:0]    wr_addr,
    input  logic [WIDTH-1:0] wr_word,
    input  logic [AW-1:0]    rd_addr,
    output logic [WIDTH-1:0] rd_word
);

    logic [WIDTH-1:0] mem [2**AW];
    logic [AW-1:0]    rd_addr_q;  // First latency cycle

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
        rd_addr_q <= rd_addr;
        rd_word   <= mem[rd_addr_q];  // Second latency cycle
    end

endmodule

/* hdl/mvu_top.sv */
// Bit-serial matrix-vector lane: controller, operand AGU, banks and product datapath
`timescale 1ns/10ps

module mvu_top
    import mvu_cfg_pkg::*;
    import mvu_ctrl_pkg::*;
#(
    parameter int N       = 16,  // Vector length and bank word width
    parameter int NCREDIT = 4    // Result credits after reset
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,          // Job start pulse
    output logic                done,           // Job done level
    output logic                irq,            // One cycle with the last result
    input  logic                d_signed,       // Input data signed
    input  logic                w_signed,       // Weights signed
    input  logic [BPREC-1:0]    iprecision,     // Input bits minus one
    input  logic [BPREC-1:0]    wprecision,     // Weight bits minus one
    input  logic [BPREC-1:0]    oprecision,     // Output bits minus one
    input  logic [BQMSBIDX-1:0] quant_msbidx,   // Quantizer window MSB
    input  logic [BDBANKA-1:0]  ibaseaddr,      // Input vector base
    input  logic [BWBANKA-1:0]  wbaseaddr,      // Weight matrix base
    input  logic [BLENGTH-1:0]  olength,        // Rows minus one
    input  logic                wrw_en,         // Weight bank write
    input  logic [BWBANKA-1:0]  wrw_addr,
    input  logic [N-1:0]        wrw_word,
    input  logic                wrc_en,         // Data bank write
    input  logic [BDBANKA-1:0]  wrc_addr,
    input  logic [N-1:0]        wrc_word,
    input  logic                result_credit,  // One per consumed result
    output logic                result_valid,
    output logic [BACC-1:0]     result_data
);

    logic               job_start;   // Start accepted by controller
    logic               row_go;      // Launch next row
    logic               row_issued;  // Last issue cycle of a row
    logic [BDBANKA-1:0] iaddr;
    logic [BWBANKA-1:0] waddr;
    logic [N-1:0]       iword;       // Input bit-plane
    logic [N-1:0]       wword;       // Weight bit-plane
    logic               neg;         // Flags aligned with bank data
    logic               first;
    logic               plane_last;
    logic               row_last;
    logic [BACC-1:0]    term;
    acc_op_t            op;
    logic               row_valid;
    logic [BACC-1:0]    row_sum;

    job_ctrl #(.NCREDIT(NCREDIT)) u_job_ctrl (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .olength       (olength),
        .result_credit (result_credit),
        .row_issued    (row_issued),
        .row_valid     (row_valid),
        .job_start     (job_start),
        .row_go        (row_go),
        .done          (done),
        .irq           (irq)
    );

    operand_agu u_agu (
        .clk        (clk),
        .rst        (rst),
        .start      (job_start),  // Config sampled only on an accepted start
        .row_go     (row_go),
        .iprecision (iprecision),
        .wprecision (wprecision),
        .ibaseaddr  (ibaseaddr),
        .wbaseaddr  (wbaseaddr),
        .d_signed   (d_signed),
        .w_signed   (w_signed),
        .iaddr      (iaddr),
        .waddr      (waddr),
        .row_issued (row_issued),
        .neg        (neg),
        .first      (first),
        .plane_last (plane_last),
        .row_last   (row_last)
    );

    bank_ram #(.WIDTH(N), .AW(BWBANKA)) u_wbank (
        .clk     (clk),
        .wr_en   (wrw_en),
        .wr_addr (wrw_addr),
        .wr_word (wrw_word),
        .rd_addr (waddr),
        .rd_word (wword)
    );

    bank_ram #(.WIDTH(N), .AW(BDBANKA)) u_dbank (
        .clk     (clk),
        .wr_en   (wrc_en),
        .wr_addr (wrc_addr),
        .wr_word (wrc_word),
        .rd_addr (iaddr),
        .rd_word (iword)
    );

    bitserial_vvp #(.N(N)) u_vvp (
        .clk        (clk),
        .rst        (rst),
        .iword      (iword),
        .wword      (wword),
        .neg        (neg),
        .first      (first),
        .plane_last (plane_last),
        .row_last   (row_last),
        .term       (term),
        .op         (op)
    );

    shift_acc u_shacc (
        .clk       (clk),
        .rst       (rst),
        .term      (term),
        .op        (op),
        .row_valid (row_valid),
        .row_sum   (row_sum)
    );

    quant_out u_quant (
        .clk          (clk),
        .rst          (rst),
        .row_valid    (row_valid),
        .row_sum      (row_sum),
        .quant_msbidx (quant_msbidx),
        .oprecision   (oprecision),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

endmodule

/* mvu_top.f */
common/mvu_cfg_pkg.sv
common/mvu_ctrl_pkg.sv
hdl/bank_ram.sv
seq/job_ctrl.sv
seq/operand_agu.sv
datapath/bitserial_vvp.sv
datapath/shift_acc.sv
datapath/quant_out.sv
hdl/mvu_top.sv
dv/mvu_top_tb.sv

/* seq/job_ctrl.sv */
// Job controller: start and row launch, result credits, done and irq
`timescale 1ns/10ps

module job_ctrl
    import mvu_cfg_pkg::*;
    import mvu_ctrl_pkg::*;
#(
    parameter int NCREDIT = 4  // Results allowed outstanding
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [BLENGTH-1:0] olength,
    input  logic               result_credit,
    input  logic               row_issued,  // AGU on last issue cycle
    input  logic               row_valid,   // Row sum leaving accumulator
    output logic               job_start,   // Accepted start
    output logic               row_go,
    output logic               done,
    output logic               irq
);

    localparam int CW = $clog2(NCREDIT + 1);

    job_state_t         state;
    logic [CW-1:0]      credit;     // Free result slots
    logic [BLENGTH:0]   issue_cnt;  // Rows launched
    logic [BLENGTH-1:0] done_cnt;   // Rows completed
    logic [BLENGTH-1:0] olen_q;
    logic               all_issued;
    logic               last_valid;

    assign job_start  = start && (state == job_idle);  // Ignored mid-job
    assign all_issued = issue_cnt == ({1'b0, olen_q} + 1'b1);
    assign last_valid = row_valid && (done_cnt == olen_q);
    // Next row launches in the last issue cycle so rows run back to back
    assign row_go = (credit != '0)
                 && ((state == job_wait_credit)
                  || (state == job_issue && row_issued && !all_issued));
    assign irq = state == job_finish;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= job_idle;
            credit    <= CW'(NCREDIT);
            issue_cnt <= '0;
            done_cnt  <= '0;
            olen_q    <= '0;
            done      <= 1'b0;
        end else begin
            credit <= credit - CW'(row_go) + CW'(result_credit);
            if (row_go) issue_cnt <= issue_cnt + 1'b1;
            if (row_valid) done_cnt <= done_cnt + 1'b1;
            case (state)
                job_idle: if (job_start) begin
                    state     <= job_wait_credit;
                    olen_q    <= olength;
                    issue_cnt <= '0;
                    done_cnt  <= '0;
                    done      <= 1'b0;  // Held until next accepted start
                end
                job_wait_credit: if (row_go) state <= job_issue;
                job_issue: if (row_issued) begin
                    if (all_issued) state <= job_drain;
                    else if (!row_go) state <= job_wait_credit;  // Stall between rows
                end
                job_drain: if (last_valid) begin
                    state <= job_finish;
                    done  <= 1'b1;  // Rises with last result_valid
                end
                default: state <= job_idle;  // Finish lasts one cycle
            endcase
        end
    end

    // Returned credits never exceed what was handed out
    assert property (@(posedge clk) disable iff (rst) credit <= CW'(NCREDIT));

endmodule

/* seq/operand_agu.sv */
// Operand address generator: walks weight and input bit-planes MSB first per row
`timescale 1ns/10ps

module operand_agu
    import mvu_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,       // Sample job config
    input  logic               row_go,      // Begin next row
    input  logic [BPREC-1:0]   iprecision,
    input  logic [BPREC-1:0]   wprecision,
    input  logic [BDBANKA-1:0] ibaseaddr,
    input  logic [BWBANKA-1:0] wbaseaddr,
    input  logic               d_signed,
    input  logic               w_signed,
    output logic [BDBANKA-1:0] iaddr,
    output logic [BWBANKA-1:0] waddr,
    output logic               row_issued,  // Last issue cycle of the row
    output logic               neg,         // Flags below lag by bank latency
    output logic               first,
    output logic               plane_last,
    output logic               row_last
);

    logic [BPREC-1:0]   iprec_q;
    logic [BPREC-1:0]   wprec_q;
    logic [BDBANKA-1:0] ibase_q;
    logic               d_signed_q;
    logic               w_signed_q;
    logic [BWBANKA-1:0] rowbase;  // Weight row start
    logic               busy;     // Issuing a row
    logic [BPREC-1:0]   icnt;     // Input bit, inner loop
    logic [BPREC-1:0]   wcnt;     // Weight bit, outer loop
    logic [3:0]         flags;
    logic [3:0]         dly [MEMRDLATENCY];

    assign iaddr      = BDBANKA'(ibase_q + icnt);
    assign waddr      = BWBANKA'(rowbase + wcnt);
    assign row_issued = busy && (icnt == '0) && (wcnt == '0);

    // {neg, first, plane_last, row_last} at issue time
    assign flags = {(d_signed_q && icnt == iprec_q) ^ (w_signed_q && wcnt == wprec_q),
                    busy && (icnt == iprec_q),
                    busy && (icnt == '0),
                    row_issued};
    assign {neg, first, plane_last, row_last} = dly[MEMRDLATENCY-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            icnt    <= '0;
            wcnt    <= '0;
            rowbase <= '0;
        end else begin
            if (start) begin
                iprec_q    <= iprecision;
                wprec_q    <= wprecision;
                ibase_q    <= ibaseaddr;
                d_signed_q <= d_signed;
                w_signed_q <= w_signed;
                rowbase    <= wbaseaddr;
            end
            if (busy) begin
                if (icnt == '0) begin
                    icnt <= iprec_q;  // Next weight plane
                    wcnt <= wcnt - 1'b1;
                end else begin
                    icnt <= icnt - 1'b1;
                end
            end
            if (row_issued) rowbase <= BWBANKA'(rowbase + wprec_q + 1'b1);
            if (row_go) begin
                busy <= 1'b1;
                icnt <= iprec_q;
                wcnt <= wprec_q;
            end else if (row_issued) begin
                busy <= 1'b0;
            end
        end
    end

    // Align flags with bank read data
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEMRDLATENCY; i++) dly[i] <= '0;
        end else begin
            dly[0] <= busy ? flags : 4'b0;
            for (int i = 1; i < MEMRDLATENCY; i++) dly[i] <= dly[i-1];
        end
    end

    // No row launch while a row is still mid-walk
    assert property (@(posedge clk) disable iff (rst) row_go |-> !busy || row_issued);

endmodule
